//--- all.f
+incdir+bench
verilog/fc_pkg.sv
verilog/fc_mul8.sv
verilog/fc_mac.sv
verilog/fc_ctrl.sv
verilog/fc_result.sv
verilog/fc_top.sv
bench/fc_tb.sv

//--- bench/fc_tb_tasks.svh
//////////////////////////////////////////////////////////////////////
// random numbers and reference model
//////////////////////////////////////////////////////////////////////

function automatic logic [7:0] rand_byte();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return lcg_state[23:16];   // low lcg bits repeat too soon
endfunction

function automatic fc_pkg::word_t rand_word();
  return {rand_byte(), rand_byte(), rand_byte(), rand_byte()};
endfunction

// bias plus the sum of feature times weight, wraps at 32 bits
function automatic logic [31:0] row_result(input int row, input int n_words);
  int            acc;
  fc_pkg::word_t fw;
  fc_pkg::word_t ww;
  byte           fb;
  byte           wb;
  acc = int'(bias_words[row]);
  for (int w = 0; w < n_words; w++) begin
    fw = feat_words[w];
    ww = weight_words[row * n_words + w];
    for (int b = 0; b < 4; b++) begin
      fb = fw[8*b +: 8];
      wb = ww[8*b +: 8];
      acc += int'(fb) * int'(wb);
    end
  end
  return acc;
endfunction

//////////////////////////////////////////////////////////////////////
// stream drivers
//////////////////////////////////////////////////////////////////////

task automatic issue_command(input fc_pkg::cmd_t cmd, input int n_feat);
  @(negedge clk);
  command = cmd;
  size    = fc_pkg::size_t'(n_feat);
  @(negedge clk);
  command = '0;   // one cycle only, idle samples it again
endtask

// tx_queue out on the slave stream, TLAST with the final word
task automatic send_words();
  int i;
  i = 0;
  while (i < tx_queue.size()) begin
    @(negedge clk);
    s_axis_tvalid = 1'b1;
    s_axis_tdata  = tx_queue[i];
    s_axis_tlast  = (i == tx_queue.size() - 1);
    #1;
    if (s_axis_tready) i++;   // taken on the next rising edge
  end
  @(negedge clk);
  s_axis_tvalid = 1'b0;
  s_axis_tlast  = 1'b0;
endtask

task automatic load_features(input int n_words);
  tx_queue.delete();
  for (int w = 0; w < n_words; w++) tx_queue.push_back(feat_words[w]);
  issue_command(3'b001, n_words * 4);
  send_words();
endtask

task automatic load_bias(input int n_rows);
  tx_queue.delete();
  for (int r = 0; r < n_rows; r++) tx_queue.push_back(bias_words[r]);
  issue_command(3'b010, 0);
  send_words();
endtask

task automatic run_weights();
  tx_queue = weight_words;
  issue_command(3'b100, 0);
  send_words();
endtask

// takes n_rows results, checks each one and any held word
task automatic collect_results(input int n_rows, input int n_words, input bit random_ready);
  int            got_cnt;
  bit            held;
  fc_pkg::word_t held_data;
  logic          held_last;
  logic [7:0]    r;
  got_cnt = 0;
  held    = 1'b0;
  while (got_cnt < n_rows) begin
    @(negedge clk);
    if (random_ready) begin
      r = rand_byte();
      m_axis_tready = r[7];
    end else begin
      m_axis_tready = 1'b1;
    end
    #1;
    if (held) begin   // stalled word must not move
      check_value("m_axis_tvalid", 32'd1, 32'(m_axis_tvalid));
      check_value("m_axis_tdata", held_data, m_axis_tdata);
      check_value("m_axis_tlast", 32'(held_last), 32'(m_axis_tlast));
    end
    held = 1'b0;
    if (m_axis_tvalid && m_axis_tready) begin
      check_value("m_axis_tdata", row_result(got_cnt, n_words), m_axis_tdata);
      check_value("m_axis_tlast", 32'(got_cnt == n_rows - 1), 32'(m_axis_tlast));
      got_cnt++;
    end else if (m_axis_tvalid) begin
      held      = 1'b1;
      held_data = m_axis_tdata;
      held_last = m_axis_tlast;
    end
  end
  @(negedge clk);   // past the final handshake
  m_axis_tready = 1'b0;
endtask

task automatic run_and_collect(input int n_words, input int n_rows, input bit random_ready);
  fork
    run_weights();
    collect_results(n_rows, n_words, random_ready);
  join
  check_value("fc_done", 32'd1, 32'(fc_done));
endtask

//////////////////////////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////////////////////////

task automatic test_reset_state();
  #1;
  check_value("s_axis_tready", 32'd0, 32'(s_axis_tready));
  check_value("m_axis_tvalid", 32'd0, 32'(m_axis_tvalid));
  check_value("fc_done", 32'd0, 32'(fc_done));
endtask

task automatic test_single_row();
  feat_words[0] = 32'h64FB0380;               // 100, -5, 3, -128
  bias_words[0] = fc_pkg::word_t'(-1000);
  weight_words.delete();
  weight_words.push_back(32'hFF02F980);       // -1, 2, -7, -128
  load_features(1);
  load_bias(1);
  run_and_collect(1, 1, 1'b0);
endtask

task automatic fill_random(input int n_words, input int n_rows);
  for (int w = 0; w < n_words; w++) feat_words[w] = rand_word();
  for (int r = 0; r < n_rows; r++) bias_words[r] = rand_word();
  weight_words.delete();
  for (int k = 0; k < n_words * n_rows; k++) weight_words.push_back(rand_word());
endtask

task automatic test_random_rows();
  fill_random(T3_FEAT_WORDS, T3_ROWS);
  load_features(T3_FEAT_WORDS);
  load_bias(T3_ROWS);
  run_and_collect(T3_FEAT_WORDS, T3_ROWS, 1'b0);
endtask

// same weights again, sink ready from the lcg
task automatic test_backpressure();
  run_and_collect(T3_FEAT_WORDS, T3_ROWS, 1'b1);
endtask

task automatic test_reload();
  fill_random(T5_FEAT_WORDS, T5_ROWS);
  load_features(T5_FEAT_WORDS);
  load_bias(T5_ROWS);
  repeat (2) @(negedge clk);
  check_value("fc_done", 32'd0, 32'(fc_done));   // cleared by the bias load
  run_and_collect(T5_FEAT_WORDS, T5_ROWS, 1'b0);
endtask

//--- bench/fc_tb.sv
`timescale 1ns/1ps

module fc_tb;

  localparam int CLK_HALF      = 4;    // 8 ns period
  localparam int LCG_SEED      = 81;
  localparam int T3_FEAT_WORDS = 8;    // 32 features
  localparam int T3_ROWS       = 8;
  localparam int T5_FEAT_WORDS = 2;    // 8 features
  localparam int T5_ROWS       = 3;

  // every word sent or received over the whole run
  localparam int TOTAL_WORDS = 4
    + T3_FEAT_WORDS + T3_ROWS + T3_FEAT_WORDS * T3_ROWS + T3_ROWS
    + T3_FEAT_WORDS * T3_ROWS + T3_ROWS
    + T5_FEAT_WORDS + T5_ROWS + T5_FEAT_WORDS * T5_ROWS + T5_ROWS;
  localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 40;

  logic          clk;
  logic          rstn;
  fc_pkg::word_t s_axis_tdata;
  logic          s_axis_tvalid;
  logic          s_axis_tlast;
  logic          s_axis_tready;
  fc_pkg::word_t m_axis_tdata;
  logic          m_axis_tvalid;
  logic          m_axis_tlast;
  logic          m_axis_tready;
  fc_pkg::cmd_t  command;
  fc_pkg::size_t size;
  logic          fc_done;

  // reference data, mirrors what was loaded into the DUT
  fc_pkg::word_t feat_words [fc_pkg::MAX_FEAT_WORDS];
  fc_pkg::word_t bias_words [fc_pkg::MAX_ROWS];
  fc_pkg::word_t weight_words [$];
  fc_pkg::word_t tx_queue [$];    // words for the next slave transfer
  logic [31:0]   lcg_state;
  int            errors;
  int            checks;

  fc_top UUT (
    .clk           (clk),
    .rstn          (rstn),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tlast  (s_axis_tlast),
    .s_axis_tready (s_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tready (m_axis_tready),
    .command       (command),
    .size          (size),
    .fc_done       (fc_done)
  );

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] got);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("FAILED %s expected %h got %h", name, expected, got);
    end
  endtask

  `include "fc_tb_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Verification failed");
    $finish;
  end

  initial begin : main
    rstn          = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
    m_axis_tready = 1'b0;
    command       = '0;
    size          = '0;
    errors        = 0;
    checks        = 0;
    lcg_state     = LCG_SEED;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;

    test_reset_state();
    test_single_row();
    test_random_rows();
    test_backpressure();
    test_reload();

    repeat (4) @(negedge clk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
  verilator --binary --assert -j 0 --top-module fc_tb -f all.f -o fc_sim &&
  ./obj_dir/fc_sim > sim.log 2>&1 ||
  { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log &&
  { echo "fc_tb reported a failure, see sim.log"; exit 1; } ||
  echo "fc_tb run clean"

//--- verilog/fc_ctrl.sv
`timescale 1ns/1ps

module fc_ctrl (
  input  logic             clk,
  input  logic             rstn,
  input  fc_pkg::word_t    s_axis_tdata,
  input  logic             s_axis_tvalid,
  input  logic             s_axis_tlast,
  output logic             s_axis_tready,
  input  fc_pkg::cmd_t     command,
  input  fc_pkg::size_t    size,
  input  logic             advance,
  output fc_pkg::mac_req_t mac_req,
  output fc_pkg::bias_wr_t bias_wr
);

  fc_pkg::fc_state_t state;
  fc_pkg::size_t     feat_size;   // latched by the feature command
  fc_pkg::addr_t     idx;         // feature word index
  fc_pkg::addr_t     last_idx;
  fc_pkg::word_t     feat_mem [fc_pkg::MAX_FEAT_WORDS];
  logic              hs;
  logic              run_hs;
  logic              bias_hs;
  logic              row_end;

  // stalls together with the pipeline
  assign s_axis_tready = (state != fc_pkg::ST_IDLE) && advance;
  assign hs            = s_axis_tvalid && s_axis_tready;
  assign run_hs        = hs && (state == fc_pkg::ST_RUN);
  assign bias_hs       = hs && (state == fc_pkg::ST_RECV_BIAS);

  assign last_idx = fc_pkg::addr_t'((feat_size >> 2) - fc_pkg::size_t'(1));
  assign row_end  = (idx == last_idx);

  //////////////////////////////////////////////////////////////////////
  // command FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state     <= fc_pkg::ST_IDLE;
      idx       <= '0;
      feat_size <= '0;
    end else begin
      case (state)
        fc_pkg::ST_IDLE: begin
          idx <= '0;
          // bit 0 wins over bit 1, bit 1 over bit 2
          if (command[0]) begin
            state     <= fc_pkg::ST_RECV_FEAT;
            feat_size <= size;
          end else if (command[1]) begin
            state <= fc_pkg::ST_RECV_BIAS;
          end else if (command[2]) begin
            state <= fc_pkg::ST_RUN;
          end
        end
        fc_pkg::ST_RECV_FEAT: begin
          if (hs) begin
            idx <= idx + fc_pkg::addr_t'(1);
            if (s_axis_tlast) state <= fc_pkg::ST_IDLE;
          end
        end
        fc_pkg::ST_RECV_BIAS: begin
          if (hs && s_axis_tlast) state <= fc_pkg::ST_IDLE;
        end
        fc_pkg::ST_RUN: begin
          if (hs) begin
            idx <= row_end ? '0 : idx + fc_pkg::addr_t'(1);   // wrap per row
            if (s_axis_tlast) state <= fc_pkg::ST_IDLE;
          end
        end
        default: state <= fc_pkg::ST_IDLE;
      endcase
    end
  end

  // feature words land by index
  always_ff @(posedge clk) begin
    if (hs && (state == fc_pkg::ST_RECV_FEAT)) begin
      feat_mem[idx] <= s_axis_tdata;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // decode output registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      mac_req.valid   <= 1'b0;
      mac_req.first   <= 1'b0;
      mac_req.last    <= 1'b0;
      mac_req.run_end <= 1'b0;
      bias_wr.valid   <= 1'b0;
      bias_wr.last    <= 1'b0;
    end else if (advance) begin
      mac_req.valid   <= run_hs;
      mac_req.first   <= run_hs && (idx == '0);
      mac_req.last    <= run_hs && (row_end || s_axis_tlast);  // short final row still closes
      mac_req.run_end <= run_hs && s_axis_tlast;
      mac_req.feat    <= feat_mem[idx];                       // registered read
      mac_req.weight  <= s_axis_tdata;
      bias_wr.valid   <= bias_hs;
      bias_wr.last    <= bias_hs && s_axis_tlast;
      bias_wr.data    <= fc_pkg::acc_t'(s_axis_tdata);
    end
  end

  // run index never passes the final word of a row
  a_idx_in_row: assert property (
    @(posedge clk) disable iff (!rstn)
    (state == fc_pkg::ST_RUN) |-> (idx <= last_idx)
  );

  // a run needs a sane feature length behind it
  a_feat_size_ok: assert property (
    @(posedge clk) disable iff (!rstn)
    (state == fc_pkg::ST_RUN) |-> (feat_size != '0) && (feat_size[1:0] == 2'b00)
  );

endmodule

//--- verilog/fc_mac.sv
`timescale 1ns/1ps

module fc_mac (
  input  logic             clk,
  input  logic             rstn,
  input  logic             advance,
  input  fc_pkg::mac_req_t mac_req,
  output fc_pkg::mac_sum_t mac_sum
);

  // row markers riding beside the data
  typedef struct packed {
    logic valid;
    logic first;
    logic last;
    logic run_end;
  } flag_t;

  flag_t         s1, s2, s3;                // mul stage 1, mul stage 2, lane sum
  fc_pkg::prod_t prod [fc_pkg::LANES];
  fc_pkg::acc_t  lane_comb;
  fc_pkg::acc_t  lane_sum;
  fc_pkg::acc_t  acc;
  fc_pkg::acc_t  acc_next;

  // byte i of feature times byte i of weight
  for (genvar i = 0; i < fc_pkg::LANES; i++) begin : g_lane
    fc_mul8 u_mul (
      .clk     (clk),
      .advance (advance),
      .a       (mac_req.feat[8*i +: 8]),
      .b       (mac_req.weight[8*i +: 8]),
      .p       (prod[i])
    );
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      s1 <= '0;
      s2 <= '0;
      s3 <= '0;
    end else if (advance) begin
      s1 <= {mac_req.valid, mac_req.first, mac_req.last, mac_req.run_end};
      s2 <= s1;
      s3 <= s2;
    end
  end

  always_comb begin
    lane_comb = '0;
    for (int i = 0; i < fc_pkg::LANES; i++) begin
      lane_comb += fc_pkg::acc_t'(prod[i]);   // sign extend
    end
  end

  always_ff @(posedge clk) begin
    if (advance) lane_sum <= lane_comb;
  end

  //////////////////////////////////////////////////////////////////////
  // row accumulator
  //////////////////////////////////////////////////////////////////////

  assign acc_next = s3.first ? lane_sum : acc + lane_sum;

  always_ff @(posedge clk) begin
    if (advance && s3.valid) acc <= acc_next;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      mac_sum.valid <= 1'b0;
      mac_sum.last  <= 1'b0;
    end else if (advance) begin
      mac_sum.valid <= s3.valid && s3.last;                // one sum per row
      mac_sum.last  <= s3.valid && s3.last && s3.run_end;
      mac_sum.sum   <= acc_next;
    end
  end

  a_flags_need_valid: assert property (
    @(posedge clk) disable iff (!rstn)
    (mac_req.first || mac_req.last) |-> mac_req.valid
  );

endmodule

//--- verilog/fc_mul8.sv
`timescale 1ns/1ps

module fc_mul8 (
  input  logic          clk,
  input  logic          advance,
  input  fc_pkg::byte_t a,
  input  fc_pkg::byte_t b,
  output fc_pkg::prod_t p
);

  logic [7:0]  mag_a;    // -128 maps to 128, still fits
  logic [7:0]  mag_b;
  logic        neg;
  logic [15:0] prod_u;

  // stage 1, magnitudes and result sign
  always_ff @(posedge clk) begin
    if (advance) begin
      mag_a <= a[7] ? ~a + 8'd1 : a;
      mag_b <= b[7] ? ~b + 8'd1 : b;
      neg   <= a[7] ^ b[7];
    end
  end

  assign prod_u = 16'(mag_a) * 16'(mag_b);   // at most 16384

  // stage 2, sign restore
  always_ff @(posedge clk) begin
    if (advance) begin
      p <= neg ? fc_pkg::prod_t'(~prod_u + 16'd1) : fc_pkg::prod_t'(prod_u);
    end
  end

endmodule

//--- verilog/fc_pkg.sv
package fc_pkg;

  //////////////////////////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////////////////////////

  localparam int DATA_W         = 32;
  localparam int LANES          = 4;    // signed bytes per stream word
  localparam int MAX_FEAT_WORDS = 256;  // 1024 features
  localparam int MAX_ROWS       = 256;

  typedef logic [DATA_W-1:0]  word_t;
  typedef logic signed [7:0]  byte_t;
  typedef logic signed [15:0] prod_t;
  typedef logic signed [31:0] acc_t;   // wraps modulo 2^32
  typedef logic [7:0]         addr_t;  // feature word index, row index
  typedef logic [10:0]        size_t;  // feature count, up to 1024
  typedef logic [2:0]         cmd_t;   // 0 feature, 1 bias, 2 weight

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RECV_FEAT,
    ST_RECV_BIAS,
    ST_RUN
  } fc_state_t;

  //////////////////////////////////////////////////////////////////////
  // stage to stage bundles
  //////////////////////////////////////////////////////////////////////

  // one weight word paired with its feature word
  typedef struct packed {
    logic  valid;
    logic  first;    // first word of a row
    logic  last;     // last word of a row
    logic  run_end;  // TLAST of the weight stream
    word_t feat;
    word_t weight;
  } mac_req_t;

  // finished row sum, bias not yet added
  typedef struct packed {
    logic valid;
    logic last;      // final row of the run
    acc_t sum;
  } mac_sum_t;

  typedef struct packed {
    logic valid;
    logic last;      // final bias word
    acc_t data;
  } bias_wr_t;

endpackage

//--- verilog/fc_result.sv
`timescale 1ns/1ps

module fc_result (
  input  logic             clk,
  input  logic             rstn,
  input  fc_pkg::bias_wr_t bias_wr,
  input  fc_pkg::mac_sum_t mac_sum,
  output logic             advance,
  output fc_pkg::word_t    m_axis_tdata,
  output logic             m_axis_tvalid,
  output logic             m_axis_tlast,
  input  logic             m_axis_tready,
  output logic             fc_done
);

  fc_pkg::acc_t  bias_mem [fc_pkg::MAX_ROWS];
  fc_pkg::addr_t wr_ptr;
  fc_pkg::addr_t rd_ptr;     // row of the next sum
  logic          out_hs;
  logic          bias_we;
  logic          sum_take;

  // low only while a result waits for the sink
  assign advance  = !m_axis_tvalid || m_axis_tready;
  assign out_hs   = m_axis_tvalid && m_axis_tready;
  assign bias_we  = advance && bias_wr.valid;
  assign sum_take = advance && mac_sum.valid;

  always_ff @(posedge clk) begin
    if (bias_we) bias_mem[wr_ptr] <= bias_wr.data;
  end

  //////////////////////////////////////////////////////////////////////
  // pointers, output valid, done flag
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      m_axis_tvalid <= 1'b0;
      fc_done       <= 1'b0;
    end else begin
      if (bias_we) begin
        wr_ptr <= bias_wr.last ? '0 : wr_ptr + fc_pkg::addr_t'(1);
      end
      if (sum_take) begin
        rd_ptr <= mac_sum.last ? '0 : rd_ptr + fc_pkg::addr_t'(1);
      end
      if (advance) m_axis_tvalid <= mac_sum.valid;   // load or drain
      if (out_hs && m_axis_tlast) begin
        fc_done <= 1'b1;
      end else if (bias_we || sum_take) begin
        fc_done <= 1'b0;          // new work has started
      end
    end
  end

  // bias add into the output register
  always_ff @(posedge clk) begin
    if (sum_take) begin
      m_axis_tdata <= fc_pkg::word_t'(mac_sum.sum + bias_mem[rd_ptr]);
      m_axis_tlast <= mac_sum.last;
    end
  end

  a_hold_stable: assert property (
    @(posedge clk) disable iff (!rstn)
    (m_axis_tvalid && !m_axis_tready) |=>
      m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast)
  );

endmodule

//--- verilog/fc_top.sv
`timescale 1ns/1ps

module fc_top (
  input  logic          clk,
  input  logic          rstn,
  // slave stream
  input  fc_pkg::word_t s_axis_tdata,
  input  logic          s_axis_tvalid,
  input  logic          s_axis_tlast,
  output logic          s_axis_tready,
  // master stream
  output fc_pkg::word_t m_axis_tdata,
  output logic          m_axis_tvalid,
  output logic          m_axis_tlast,
  input  logic          m_axis_tready,
  // command and status
  input  fc_pkg::cmd_t  command,
  input  fc_pkg::size_t size,
  output logic          fc_done
);

  fc_pkg::mac_req_t mac_req;
  fc_pkg::bias_wr_t bias_wr;
  fc_pkg::mac_sum_t mac_sum;
  logic             advance;   // pipeline enable from the result stage

  // decode
  fc_ctrl u_ctrl (
    .clk           (clk),
    .rstn          (rstn),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tlast  (s_axis_tlast),
    .s_axis_tready (s_axis_tready),
    .command       (command),
    .size          (size),
    .advance       (advance),
    .mac_req       (mac_req),
    .bias_wr       (bias_wr)
  );

  // execute
  fc_mac u_mac (
    .clk     (clk),
    .rstn    (rstn),
    .advance (advance),
    .mac_req (mac_req),
    .mac_sum (mac_sum)
  );

  // bias add and output
  fc_result u_result (
    .clk           (clk),
    .rstn          (rstn),
    .bias_wr       (bias_wr),
    .mac_sum       (mac_sum),
    .advance       (advance),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tready (m_axis_tready),
    .fc_done       (fc_done)
  );

endmodule
